// ==== list.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/cpu_sequencer.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/data_port.sv
rtl/serial_cpu.sv
test/tb_serial_cpu.sv

// ==== rtl/cpu_pkg.sv ====
// serial CPU opcode, state and run status types with opcode class decoding
`default_nettype none
`include "cpu_settings.svh"

package cpu_pkg;

    typedef enum logic [`CPU_OPCODE_W-1:0] {
        NOP, HALT, LOAD, STORE, LDIH, SUIH, ADD, ADDI, SUB, SUBI, CMP, AND, OR,
        XOR, SLL, SRL, SET, JUMP, JMPR, BZ, BNZ, BN, BNN, BC, BNC
    } opcode_t;

    // seven states per instruction, idle between runs
    typedef enum logic [2:0] {
        IDLE, FETCH_HI, FETCH_LO, DECODE, EXECUTE, MEM_LO, MEM_HI, WRITE_BACK
    } cpu_state_t;

    typedef enum logic [1:0] {
        RUNNING     = 2'd0,
        HALTED      = 2'd1,
        PROGRAM_END = 2'd2
    } run_status_t;

    // ----------------------------------------
    // opcode classes
    // ----------------------------------------
    function automatic logic writes_flags(input opcode_t op);
        return op inside {LDIH, SUIH, ADD, ADDI, SUB, SUBI, CMP, AND, OR, XOR, SLL, SRL};
    endfunction

    function automatic logic writes_reg(input opcode_t op);
        return op inside {LOAD, LDIH, SUIH, ADD, ADDI, SUB, SUBI, AND, OR, XOR, SLL, SRL, SET};
    endfunction

    // operand a from r1, immediate and branch forms
    function automatic logic a_from_r1(input opcode_t op);
        return op inside {LDIH, SUIH, ADDI, SUBI, JMPR, BZ, BNZ, BN, BNN, BC, BNC};
    endfunction

    function automatic logic a_from_r2(input opcode_t op);
        return op inside {LOAD, STORE, ADD, SUB, CMP, AND, OR, XOR, SLL, SRL};
    endfunction

    function automatic logic b_from_r3(input opcode_t op);
        return op inside {ADD, SUB, CMP, AND, OR, XOR};
    endfunction

    // address offset or shift amount
    function automatic logic b_imm4(input opcode_t op);
        return op inside {LOAD, STORE, SLL, SRL};
    endfunction

    function automatic logic b_imm8(input opcode_t op);
        return op inside {ADDI, SUBI, SET, JUMP, JMPR, BZ, BNZ, BN, BNN, BC, BNC};
    endfunction

    function automatic logic b_imm8_high(input opcode_t op);
        return op inside {LDIH, SUIH};
    endfunction

endpackage

`default_nettype wire

// ==== rtl/cpu_sequencer.sv ====
// instruction cycle state machine with run status reporting
`timescale 1ns/1ns
`default_nettype none

module cpu_sequencer (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  start,
    input  cpu_pkg::opcode_t     opcode,
    input  wire                  program_end,
    output cpu_pkg::cpu_state_t  state,
    output cpu_pkg::run_status_t run_status
);
    import cpu_pkg::*;

    cpu_state_t next_state;

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:       if (start) next_state = FETCH_HI;
            FETCH_HI:   next_state = FETCH_LO;
            FETCH_LO:   next_state = DECODE;
            DECODE:     next_state = EXECUTE;
            EXECUTE:    next_state = MEM_LO;
            MEM_LO:     next_state = MEM_HI;
            MEM_HI:     next_state = WRITE_BACK;
            WRITE_BACK: next_state = (opcode == HALT || program_end) ? IDLE : FETCH_HI;
            default:    next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= IDLE;
            run_status <= RUNNING;
        end
        else
        begin
            state <= next_state;
            if (state == IDLE && start)
                run_status <= RUNNING;
            else if (state == WRITE_BACK && opcode == HALT)
                run_status <= HALTED;
            else if (state == WRITE_BACK && program_end)
                run_status <= PROGRAM_END;
        end
    end

    // a run begins only on start
    assert property (@(posedge clk) disable iff (!rst_n)
        (state == IDLE && !start) |=> state == IDLE);

endmodule

`default_nettype wire

// ==== rtl/cpu_settings.svh ====
// serial CPU widths, register count and program end address
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------
// register and instruction word
`define CPU_WORD_W 16
// memory bus data, one byte per cycle
`define CPU_BYTE_W 8

// ----------------------------------------
// addressing
// ----------------------------------------
`define CPU_PC_W 8
`define CPU_BYTE_ADDR_W 9
// last instruction word, the run stops here
`define CPU_PC_END ({`CPU_PC_W{1'b1}})

// ----------------------------------------
// register file and decode
// ----------------------------------------
`define CPU_NUM_REGS 8
`define CPU_REG_IDX_W 3
`define CPU_OPCODE_W 5

`endif

// ==== rtl/data_port.sv ====
// byte serial data memory access and register write back request
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module data_port (
    input  wire                          clk,
    input  wire                          rst_n,
    input  cpu_pkg::cpu_state_t          state,
    input  cpu_pkg::opcode_t             opcode,
    input  wire [`CPU_REG_IDX_W-1:0]     r1_idx,
    input  wire [`CPU_WORD_W-1:0]        result,
    input  wire [`CPU_WORD_W-1:0]        store_data,
    input  wire [`CPU_BYTE_W-1:0]        d_rdata,
    output logic [`CPU_BYTE_ADDR_W-1:0]  d_addr,
    output logic                         d_we,
    output logic [`CPU_BYTE_W-1:0]       d_wdata,
    output logic                         reg_we,
    output logic [`CPU_REG_IDX_W-1:0]    reg_wr_idx,
    output logic [`CPU_WORD_W-1:0]       reg_wr_data
);
    import cpu_pkg::*;

    logic                   mem_phase;
    logic [`CPU_WORD_W-1:0] load_word;

    // low byte at the even address
    assign mem_phase = (state == MEM_LO) || (state == MEM_HI);
    assign d_addr    = mem_phase ? {result[`CPU_PC_W-1:0], state == MEM_HI} : '0;
    assign d_we      = mem_phase && (opcode == STORE);
    assign d_wdata   = (state == MEM_HI) ? store_data[`CPU_WORD_W-1:`CPU_BYTE_W]
                                         : store_data[`CPU_BYTE_W-1:0];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            load_word <= '0;
        else if (state == MEM_LO)
            load_word[`CPU_BYTE_W-1:0] <= d_rdata;
        else if (state == MEM_HI)
            load_word[`CPU_WORD_W-1:`CPU_BYTE_W] <= d_rdata;
    end

    assign reg_we      = (state == WRITE_BACK) && writes_reg(opcode);
    assign reg_wr_idx  = r1_idx;
    assign reg_wr_data = (opcode == LOAD) ? load_word : result;

    // a store drives exactly two write cycles, low byte first
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(d_we) |-> (opcode == STORE && state == MEM_LO)
            ##1 (d_we && state == MEM_HI) ##1 !d_we);

endmodule

`default_nettype wire

// ==== rtl/execute_unit.sv ====
// operand select, ALU, condition flags and branch decision
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module execute_unit (
    input  wire                         clk,
    input  wire                         rst_n,
    input  cpu_pkg::cpu_state_t         state,
    input  wire [`CPU_WORD_W-1:0]       instr,
    output logic [`CPU_REG_IDX_W-1:0]   rd_idx_a,
    output logic [`CPU_REG_IDX_W-1:0]   rd_idx_b,
    output logic [`CPU_REG_IDX_W-1:0]   rd_idx_c,
    input  wire [`CPU_WORD_W-1:0]       rd_data_a,
    input  wire [`CPU_WORD_W-1:0]       rd_data_b,
    input  wire [`CPU_WORD_W-1:0]       rd_data_c,
    output logic [`CPU_WORD_W-1:0]      result,
    output logic [`CPU_WORD_W-1:0]      store_data,
    output logic                        take_branch,
    output logic [`CPU_PC_W-1:0]        branch_target
);
    import cpu_pkg::*;

    opcode_t                opcode;
    logic [`CPU_WORD_W-1:0] sel_a, sel_b, op_a, op_b, alu_out;
    logic                   alu_carry;
    logic                   zf, nf, cf;
    logic                   cond;

    assign opcode   = opcode_t'(instr[15:11]);
    assign rd_idx_a = instr[10:8];
    assign rd_idx_b = instr[6:4];
    assign rd_idx_c = instr[2:0];

    // ----------------------------------------
    // operand select, latched in DECODE
    // ----------------------------------------
    always_comb
    begin
        sel_a = '0;
        if (a_from_r1(opcode))
            sel_a = rd_data_a;
        else if (a_from_r2(opcode))
            sel_a = rd_data_b;
        sel_b = '0;
        if (b_from_r3(opcode))
            sel_b = rd_data_c;
        else if (b_imm4(opcode))
            sel_b = {{(`CPU_WORD_W-4){1'b0}}, instr[3:0]};
        else if (b_imm8(opcode))
            sel_b = {{(`CPU_WORD_W-8){1'b0}}, instr[7:0]};
        else if (b_imm8_high(opcode))
            sel_b = {instr[7:0], {(`CPU_WORD_W-8){1'b0}}};
    end

    // ----------------------------------------
    // ALU, carry holds over for shifts
    // ----------------------------------------
    always_comb
    begin
        alu_carry = cf;
        case (opcode)
            SUB, SUBI, SUIH, CMP: {alu_carry, alu_out} = {1'b0, op_a} - {1'b0, op_b};
            AND:     {alu_carry, alu_out} = {1'b0, op_a & op_b};
            OR:      {alu_carry, alu_out} = {1'b0, op_a | op_b};
            XOR:     {alu_carry, alu_out} = {1'b0, op_a ^ op_b};
            SLL:     alu_out = op_a << op_b[3:0];
            SRL:     alu_out = op_a >> op_b[3:0];
            // add also forms addresses and jump targets
            default: {alu_carry, alu_out} = {1'b0, op_a} + {1'b0, op_b};
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (state == DECODE)
        begin
            op_a <= sel_a;
            op_b <= sel_b;
            if (opcode == STORE)
                store_data <= rd_data_a;
        end
        if (state == EXECUTE)
            result <= alu_out;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            {zf, nf, cf} <= '0;
        else if (state == EXECUTE && writes_flags(opcode))
            {zf, nf, cf} <= {alu_out == '0, alu_out[`CPU_WORD_W-1], alu_carry};
    end

    always_comb
    begin
        case (opcode)
            JUMP, JMPR: cond = 1'b1;
            BZ:         cond = zf;
            BNZ:        cond = !zf;
            BN:         cond = nf;
            BNN:        cond = !nf;
            BC:         cond = cf;
            BNC:        cond = !cf;
            default:    cond = 1'b0;
        endcase
    end

    assign take_branch   = (state == WRITE_BACK) && cond;
    assign branch_target = result[`CPU_PC_W-1:0];

    assert property (@(posedge clk) disable iff (!rst_n)
        !$stable({zf, nf, cf}) |-> $past(state) == EXECUTE);

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
// program counter and two byte instruction fetch
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module fetch_unit (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          start,
    input  cpu_pkg::cpu_state_t          state,
    input  wire [`CPU_BYTE_W-1:0]        i_rdata,
    input  wire                          take_branch,
    input  wire [`CPU_PC_W-1:0]          branch_target,
    output logic [`CPU_BYTE_ADDR_W-1:0]  i_addr,
    output logic [`CPU_WORD_W-1:0]       instr,
    output logic                         program_end
);
    import cpu_pkg::*;

    logic [`CPU_PC_W-1:0] pc;

    // high byte at the even address, low byte at the odd one
    assign i_addr      = {pc, state == FETCH_LO};
    assign program_end = (pc == `CPU_PC_END);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc    <= '0;
            instr <= '0;
        end
        else
        begin
            if (state == FETCH_HI)
                instr[`CPU_WORD_W-1:`CPU_BYTE_W] <= i_rdata;
            if (state == FETCH_LO)
                instr[`CPU_BYTE_W-1:0] <= i_rdata;
            if (state == IDLE && start)
                pc <= '0;
            else if (state == WRITE_BACK && take_branch)
                pc <= branch_target;
            else if (state == WRITE_BACK && !program_end)
                pc <= pc + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(pc) |-> $past(state) inside {IDLE, WRITE_BACK});

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
// general register file, three read ports and one write port
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module reg_file (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [`CPU_REG_IDX_W-1:0]    rd_idx_a,
    input  wire [`CPU_REG_IDX_W-1:0]    rd_idx_b,
    input  wire [`CPU_REG_IDX_W-1:0]    rd_idx_c,
    output logic [`CPU_WORD_W-1:0]      rd_data_a,
    output logic [`CPU_WORD_W-1:0]      rd_data_b,
    output logic [`CPU_WORD_W-1:0]      rd_data_c,
    input  wire                         we,
    input  wire [`CPU_REG_IDX_W-1:0]    wr_idx,
    input  wire [`CPU_WORD_W-1:0]       wr_data
);
    logic [`CPU_WORD_W-1:0] regs [`CPU_NUM_REGS];

    // reads are combinational
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];
    assign rd_data_c = regs[rd_idx_c];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we)
            regs[wr_idx] <= wr_data;
    end

endmodule

`default_nettype wire

// ==== rtl/serial_cpu.sv ====
// serial CPU top, multicycle core on byte wide instruction and data buses
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module serial_cpu (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          start,
    output wire [`CPU_BYTE_ADDR_W-1:0]   i_addr,
    input  wire [`CPU_BYTE_W-1:0]        i_rdata,
    output wire [`CPU_BYTE_ADDR_W-1:0]   d_addr,
    output wire                          d_we,
    output wire [`CPU_BYTE_W-1:0]        d_wdata,
    input  wire [`CPU_BYTE_W-1:0]        d_rdata,
    output cpu_pkg::run_status_t         run_status
);
    import cpu_pkg::*;

    cpu_state_t                 state;
    opcode_t                    opcode;
    logic [`CPU_WORD_W-1:0]     instr;
    logic                       program_end;
    logic                       take_branch;
    logic [`CPU_PC_W-1:0]       branch_target;
    logic [`CPU_REG_IDX_W-1:0]  rd_idx_a, rd_idx_b, rd_idx_c, reg_wr_idx;
    logic [`CPU_WORD_W-1:0]     rd_data_a, rd_data_b, rd_data_c;
    logic [`CPU_WORD_W-1:0]     result, store_data, reg_wr_data;
    logic                       reg_we;

    // opcode sits in the top five instruction bits
    assign opcode = opcode_t'(instr[15:11]);

    cpu_sequencer cpu_sequencer_i (.clk, .rst_n, .start, .opcode, .program_end, .state,
        .run_status);

    fetch_unit fetch_unit_i (.clk, .rst_n, .start, .state, .i_rdata, .take_branch,
        .branch_target, .i_addr, .instr, .program_end);

    reg_file reg_file_i (.clk, .rst_n, .rd_idx_a, .rd_idx_b, .rd_idx_c, .rd_data_a,
        .rd_data_b, .rd_data_c, .we(reg_we), .wr_idx(reg_wr_idx), .wr_data(reg_wr_data));

    execute_unit execute_unit_i (.clk, .rst_n, .state, .instr, .rd_idx_a, .rd_idx_b,
        .rd_idx_c, .rd_data_a, .rd_data_b, .rd_data_c, .result, .store_data, .take_branch,
        .branch_target);

    data_port data_port_i (.clk, .rst_n, .state, .opcode, .r1_idx(instr[10:8]), .result,
        .store_data, .d_rdata, .d_addr, .d_we, .d_wdata, .reg_we, .reg_wr_idx, .reg_wr_data);

endmodule

`default_nettype wire

// ==== test/tb_serial_cpu.sv ====
// serial CPU testbench with byte memories, an instruction level model and directed programs
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module tb_serial_cpu;
    import cpu_pkg::*;

    logic                         clk;
    logic                         rst_n;
    logic                         start;
    logic [`CPU_BYTE_ADDR_W-1:0]  i_addr;
    logic [`CPU_BYTE_W-1:0]       i_rdata;
    logic [`CPU_BYTE_ADDR_W-1:0]  d_addr;
    logic                         d_we;
    logic [`CPU_BYTE_W-1:0]       d_wdata;
    logic [`CPU_BYTE_W-1:0]       d_rdata;
    run_status_t                  run_status;

    logic [7:0]  imem [512];
    logic [7:0]  dmem [512];
    logic [7:0]  m_dmem [512];
    logic [15:0] m_regs [8];
    logic        m_zf, m_nf, m_cf;
    logic [31:0] lfsr_state = 32'h2250bc45;
    int          prog_len = 0;
    int          write_count = 0;
    int          tests = 0;
    int          checks = 0;
    int          errors = 0;
    string       cur_test;

    serial_cpu serial_cpu_i (.clk, .rst_n, .start, .i_addr, .i_rdata, .d_addr, .d_we,
        .d_wdata, .d_rdata, .run_status);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------
    // memory models with combinational reads
    // ----------------------------------------
    assign i_rdata = imem[i_addr];
    assign d_rdata = dmem[d_addr];

    always @(posedge clk)
    begin
        if (d_we)
        begin
            dmem[d_addr] <= d_wdata;
            write_count  <= write_count + 1;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[14:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected === actual)
        else
        begin
            errors++;
            $display("mismatch %s %s: expected %0h, actual %0h", cur_test, what, expected,
                actual);
        end
    endtask

    task automatic report_test(input string name, input int err0, input int chk0);
        tests++;
        $display("test %s %s, %0d checks, %0d errors", name,
            (errors == err0) ? "ok" : "failed", checks - chk0, errors - err0);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < 8; i++)
            m_regs[i] = '0;
        {m_zf, m_nf, m_cf} = '0;
    endtask

    // ----------------------------------------
    // program assembly
    // ----------------------------------------
    task automatic clear_memories();
        for (int i = 0; i < 512; i++)
        begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        prog_len = 0;
    endtask

    task automatic put_word(input logic [15:0] word);
        imem[2 * prog_len]     = word[15:8];
        imem[2 * prog_len + 1] = word[7:0];
        prog_len++;
    endtask

    // register forms with r3 or imm4 in the low four bits
    task automatic emit(input opcode_t op, input logic [2:0] r1, input logic [2:0] r2,
                        input logic [3:0] low4);
        put_word({op, r1, 1'b0, r2, low4});
    endtask

    task automatic emit_imm(input opcode_t op, input logic [2:0] r1, input logic [7:0] imm8);
        put_word({op, r1, imm8});
    endtask

    task automatic set_reg(input logic [2:0] r, input logic [15:0] value);
        emit_imm(SET, r, value[7:0]);
        emit_imm(LDIH, r, value[15:8]);
    endtask

    // ----------------------------------------
    // instruction level reference model
    // ----------------------------------------
    task automatic write_result(input logic [2:0] dest, input logic [15:0] v, input logic wr);
        m_zf = (v == 16'h0000);
        m_nf = v[15];
        if (wr)
            m_regs[dest] = v;
    endtask

    task automatic model_arith(input logic [2:0] dest, input logic [15:0] x,
                               input logic [15:0] y, input logic sub, input logic wr);
        logic [16:0] wide;
        wide = sub ? ({1'b0, x} - {1'b0, y}) : ({1'b0, x} + {1'b0, y});
        m_cf = wide[16];
        write_result(dest, wide[15:0], wr);
    endtask

    function automatic logic flag_holds(input opcode_t op);
        case (op)
            BZ:      return m_zf;
            BNZ:     return !m_zf;
            BN:      return m_nf;
            BNN:     return !m_nf;
            BC:      return m_cf;
            BNC:     return !m_cf;
            default: return op == JMPR;
        endcase
    endfunction

    task automatic run_model(output run_status_t status, output int steps, output int writes);
        logic [7:0]  pc, next_pc, waddr;
        logic [15:0] w, sum;
        logic [2:0]  r1, r2, r3;
        opcode_t     op;
        logic        done;
        pc = '0;
        steps = 0;
        writes = 0;
        status = RUNNING;
        done = 1'b0;
        while (!done && steps < 4096)
        begin
            w = {imem[{pc, 1'b0}], imem[{pc, 1'b1}]};
            op = opcode_t'(w[15:11]);
            r1 = w[10:8];
            r2 = w[6:4];
            r3 = w[2:0];
            sum = m_regs[r2] + {12'h000, w[3:0]};
            waddr = sum[7:0];
            next_pc = pc + 8'd1;
            steps++;
            case (op)
                HALT:  done = 1'b1;
                LOAD:  m_regs[r1] = {m_dmem[{waddr, 1'b1}], m_dmem[{waddr, 1'b0}]};
                STORE:
                begin
                    m_dmem[{waddr, 1'b0}] = m_regs[r1][7:0];
                    m_dmem[{waddr, 1'b1}] = m_regs[r1][15:8];
                    writes += 2;
                end
                ADD:   model_arith(r1, m_regs[r2], m_regs[r3], 1'b0, 1'b1);
                SUB:   model_arith(r1, m_regs[r2], m_regs[r3], 1'b1, 1'b1);
                CMP:   model_arith(r1, m_regs[r2], m_regs[r3], 1'b1, 1'b0);
                ADDI:  model_arith(r1, m_regs[r1], {8'h00, w[7:0]}, 1'b0, 1'b1);
                SUBI:  model_arith(r1, m_regs[r1], {8'h00, w[7:0]}, 1'b1, 1'b1);
                LDIH:  model_arith(r1, m_regs[r1], {w[7:0], 8'h00}, 1'b0, 1'b1);
                SUIH:  model_arith(r1, m_regs[r1], {w[7:0], 8'h00}, 1'b1, 1'b1);
                AND, OR, XOR:
                begin
                    m_cf = 1'b0;
                    if (op == AND)
                        write_result(r1, m_regs[r2] & m_regs[r3], 1'b1);
                    else if (op == OR)
                        write_result(r1, m_regs[r2] | m_regs[r3], 1'b1);
                    else
                        write_result(r1, m_regs[r2] ^ m_regs[r3], 1'b1);
                end
                SLL:   write_result(r1, m_regs[r2] << w[3:0], 1'b1);
                SRL:   write_result(r1, m_regs[r2] >> w[3:0], 1'b1);
                SET:   m_regs[r1] = {8'h00, w[7:0]};
                JUMP:  next_pc = w[7:0];
                JMPR, BZ, BNZ, BN, BNN, BC, BNC:
                    if (flag_holds(op))
                        next_pc = m_regs[r1][7:0] + w[7:0];
                default: ;
            endcase
            if (done)
                status = HALTED;
            else if (pc == 8'hff)
            begin
                status = PROGRAM_END;
                done = 1'b1;
            end
            pc = next_pc;
        end
    endtask

    // ----------------------------------------
    // run one program and compare with the model
    // ----------------------------------------
    task automatic run_program(input string name);
        run_status_t exp_status;
        int          steps, exp_writes, cycles, writes0, err0, chk0;
        cur_test = name;
        err0 = errors;
        chk0 = checks;
        m_dmem = dmem;
        run_model(exp_status, steps, exp_writes);
        writes0 = write_count;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        cycles = 0;
        while (run_status == RUNNING && cycles <= 7 * steps + 20)
        begin
            @(negedge clk);
            cycles++;
        end
        if (run_status == RUNNING)
        begin
            errors++;
            $display("%s timed out, run status stayed RUNNING after %0d cycles", name, cycles);
            apply_reset();
        end
        else
        begin
            check_value("run status", exp_status, run_status);
            check_value("cycle count", 7 * steps, cycles);
            check_value("data writes", exp_writes, write_count - writes0);
            for (int w = 0; w < 256; w++)
                check_value($sformatf("data word %0d", w), {m_dmem[2 * w + 1], m_dmem[2 * w]},
                    {dmem[2 * w + 1], dmem[2 * w]});
        end
        report_test(name, err0, chk0);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_reset_state();
        int err0, chk0;
        cur_test = "reset_state";
        err0 = errors;
        chk0 = checks;
        check_value("run status", RUNNING, run_status);
        repeat (5)
        begin
            @(negedge clk);
            check_value("d_we", 1'b0, d_we);
        end
        check_value("data writes", 0, write_count);
        report_test(cur_test, err0, chk0);
    endtask

    task automatic test_alu_ops();
        opcode_t ops [5] = '{ADD, SUB, AND, OR, XOR};
        clear_memories();
        emit_imm(SET, 7, 8'h40);
        set_reg(1, rand_bits(16));
        set_reg(2, rand_bits(16));
        for (int i = 0; i < 5; i++)
        begin
            emit(ops[i], 3, 1, {1'b0, 3'd2});
            emit(STORE, 3, 7, i);
        end
        emit_imm(HALT, 0, 8'h00);
        run_program("alu_ops");
    endtask

    task automatic test_immediates();
        opcode_t ops [4] = '{ADDI, SUBI, LDIH, SUIH};
        clear_memories();
        emit_imm(SET, 7, 8'h50);
        for (int i = 0; i < 4; i++)
        begin
            set_reg(1, rand_bits(16));
            emit_imm(ops[i], 1, rand_bits(8));
            emit(STORE, 1, 7, i);
        end
        for (int i = 0; i < 2; i++)
        begin
            set_reg(1, rand_bits(16));
            emit((i == 0) ? SLL : SRL, 2, 1, rand_bits(4));
            emit(STORE, 2, 7, 4 + i);
        end
        emit_imm(HALT, 0, 8'h00);
        run_program("immediates");
    endtask

    task automatic test_load_copy();
        logic [15:0] v;
        clear_memories();
        for (int w = 0; w < 8; w++)
        begin
            v = rand_bits(16);
            dmem[2 * w]     = v[7:0];
            dmem[2 * w + 1] = v[15:8];
        end
        emit_imm(SET, 6, 8'h00);
        emit_imm(SET, 7, 8'h80);
        for (int i = 0; i < 8; i++)
        begin
            emit(LOAD, 1, 6, i);
            emit(STORE, 1, 7, i);
        end
        emit_imm(HALT, 0, 8'h00);
        run_program("load_copy");
    endtask

    // each taken branch skips the marker store after it
    task automatic test_branches();
        opcode_t brs [6] = '{BZ, BNZ, BN, BNN, BC, BNC};
        clear_memories();
        emit_imm(SET, 6, 8'h03);
        emit_imm(SET, 7, 8'h98);
        set_reg(5, rand_bits(16) | 16'h0001);
        set_reg(2, rand_bits(16));
        set_reg(3, rand_bits(16));
        for (int s = 0; s < 4; s++)
        begin
            emit_imm(ADDI, 7, 8'h08);
            case (s)
                0:       emit(CMP, 0, 2, {1'b0, 3'd2});
                1:       emit(CMP, 0, 2, {1'b0, 3'd3});
                2:       emit(CMP, 0, 3, {1'b0, 3'd2});
                default: emit(ADD, 4, 2, {1'b0, 3'd3});
            endcase
            for (int b = 0; b < 6; b++)
            begin
                emit_imm(brs[b], 6, prog_len + 2 - 3);
                emit(STORE, 5, 7, b);
            end
        end
        emit_imm(JUMP, 0, prog_len + 2);
        emit(STORE, 5, 7, 6);
        emit_imm(JMPR, 6, prog_len + 2 - 3);
        emit(STORE, 5, 7, 7);
        emit(STORE, 5, 7, 8);
        emit_imm(HALT, 0, 8'h00);
        run_program("branches");
    endtask

    task automatic test_program_end();
        clear_memories();
        run_program("program_end");
    endtask

    initial
    begin
        rst_n = 1'b0;
        start = 1'b0;
        clear_memories();
        apply_reset();
        test_reset_state();
        test_alu_ops();
        test_immediates();
        test_load_copy();
        test_branches();
        test_program_end();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
